// ==== robTop.f ====
+incdir+source
source/robPkg.sv
source/robControl.sv
source/robEntryTable.sv
source/registerStatus.sv
source/operandRead.sv
source/archRegFile.sv
source/robTop.sv
test/robTopTb.sv

// ==== Makefile ====
SOURCES = $(shell grep -v '^+' robTop.f) source/rob_defs.svh

obj_dir/VrobTopTb: robTop.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module robTopTb -f robTop.f -o VrobTopTb

run: obj_dir/VrobTopTb
	./obj_dir/VrobTopTb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== test/robTopTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module robTopTb;

    localparam int          RESET_CYCLES   = 16;
    localparam int          RUN_CYCLES     = 3000;
    localparam int          PHASE_CYCLES   = 40;
    localparam int          TIMEOUT_CYCLES = 3500;  // run, final drain and sweep, plus margin
    localparam logic [31:0] SEED           = 32'h76c0ff2f;

    // model view of one in-flight instruction
    typedef struct packed {
        robPkg::robTag_t   tag;
        robPkg::regAddr_t  destReg;
        logic              hasDest;
        logic              done;
        robPkg::dataWord_t value;
        logic              redirect;
    } modelEntry_t;

    logic                CLK;
    logic                Reset;
    robPkg::issueReq_t   issue;
    robPkg::cdbBus_t     cdb;
    robPkg::regAddr_t    srcA;
    robPkg::regAddr_t    srcB;
    logic                full;
    robPkg::robTag_t     issueTag;
    robPkg::commitInfo_t commit;
    robPkg::operand_t    operandA;
    robPkg::operand_t    operandB;

    logic [31:0]        lfsr;
    int                 cycleCount = 0;
    modelEntry_t        robQueue [$];           // oldest first
    robPkg::dataWord_t  modelRegs [`REG_COUNT];
    robPkg::regStatus_t producer [`REG_COUNT];
    robPkg::robTag_t    tailTag;
    int                 portDone [`CDB_PORTS];
    int                 fullCycles;
    int                 redirectCommits;
    int                 regWrites;
    logic               coverageOk;

    robTop DUT (
        .CLK      (CLK),
        .Reset    (Reset),
        .issue    (issue),
        .cdb      (cdb),
        .srcA     (srcA),
        .srcB     (srcB),
        .full     (full),
        .issueTag (issueTag),
        .commit   (commit),
        .operandA (operandA),
        .operandB (operandB)
    );

    always #2 CLK = ~CLK;

    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
            abortRun();
        end
    end

    // ------------------------------------------------------------------------
    // random source, x^32 + x^22 + x^2 + x + 1
    // ------------------------------------------------------------------------
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = stepLfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped on a failure");
    endtask

    task automatic checkValue(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
        assert (actual == expected)
        else begin
            $display("[ERROR] %s: got %0h, expected %0h", name, actual, expected);
            abortRun();
        end
    endtask

    task automatic checkOperand(input string name, input robPkg::operand_t actual,
                                input robPkg::operand_t expected);
        checkValue({name, ".ready"}, 64'(actual.ready), 64'(expected.ready));
        checkValue({name, ".value"}, 64'(actual.value), 64'(expected.value));
        checkValue({name, ".tag"}, 64'(actual.tag), 64'(expected.tag));
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic int findEntry(input robPkg::robTag_t tag);
        int idx;
        idx = -1;
        for (int i = 0; i < robQueue.size(); i++) begin
            if (robQueue[i].tag == tag) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic robPkg::commitInfo_t expectedCommit();
        robPkg::commitInfo_t expected;
        expected = '0;
        if (robQueue.size() > 0 && robQueue[0].done) begin
            expected.valid    = 1'b1;
            expected.destReg  = robQueue[0].destReg;
            expected.value    = robQueue[0].value;
            expected.redirect = robQueue[0].redirect;
            expected.writeReg = robQueue[0].hasDest && !robQueue[0].redirect;
        end
        return expected;
    endfunction

    function automatic robPkg::operand_t expectedOperand(input robPkg::regAddr_t src);
        robPkg::operand_t expected;
        int               idx;
        expected = '0;
        if (!producer[src].busy) begin
            expected.ready = 1'b1;
            expected.value = modelRegs[src];
        end
        else begin
            expected.tag = producer[src].tag;
            idx = findEntry(producer[src].tag);
            if (idx >= 0 && robQueue[idx].done) begin
                expected.ready = 1'b1;           // forwarded from the buffer
                expected.value = robQueue[idx].value;
            end
        end
        return expected;
    endfunction

    task automatic applyEdge();
        robPkg::commitInfo_t retire;
        modelEntry_t         entry;
        logic                wasFull;
        int                  idx;
        retire  = expectedCommit();
        wasFull = (robQueue.size() == `ROB_ENTRIES);
        if (wasFull) begin
            fullCycles++;
        end
        for (int p = 0; p < `CDB_PORTS; p++) begin
            idx = cdb[p].valid ? findEntry(cdb[p].tag) : -1;   // free entries ignore results
            if (idx >= 0) begin
                entry          = robQueue[idx];
                entry.done     = 1'b1;
                entry.value    = cdb[p].value;
                entry.redirect = (p == 0) && cdb[p].redirect;
                robQueue[idx]  = entry;
                portDone[p]++;
            end
        end
        if (retire.valid) begin
            entry = robQueue.pop_front();
            if (retire.writeReg) begin
                modelRegs[entry.destReg] = entry.value;
                regWrites++;
                if (producer[entry.destReg].busy && producer[entry.destReg].tag == entry.tag) begin
                    producer[entry.destReg].busy = 1'b0;
                end
            end
        end
        if (retire.valid && retire.redirect) begin
            // squash everything younger, same-cycle issue included
            robQueue.delete();
            for (int r = 0; r < `REG_COUNT; r++) begin
                producer[r] = '0;
            end
            tailTag = entry.tag + robPkg::robTag_t'(1);
            redirectCommits++;
        end
        else if (issue.valid && !wasFull) begin
            entry          = '0;
            entry.tag      = tailTag;
            entry.destReg  = issue.destReg;
            entry.hasDest  = issue.hasDest;
            robQueue.push_back(entry);
            if (issue.hasDest) begin
                producer[issue.destReg] = '{busy: 1'b1, tag: tailTag};
            end
            tailTag = tailTag + robPkg::robTag_t'(1);
        end
    endtask

    task automatic checkOutputs();
        robPkg::commitInfo_t expected;
        expected = expectedCommit();
        checkValue("full", 64'(full), 64'(robQueue.size() == `ROB_ENTRIES));
        checkValue("issueTag", 64'(issueTag), 64'(tailTag));
        checkValue("commit.valid", 64'(commit.valid), 64'(expected.valid));
        checkValue("commit.destReg", 64'(commit.destReg), 64'(expected.destReg));
        checkValue("commit.value", 64'(commit.value), 64'(expected.value));
        checkValue("commit.writeReg", 64'(commit.writeReg), 64'(expected.writeReg));
        checkValue("commit.redirect", 64'(commit.redirect), 64'(expected.redirect));
        checkOperand("operandA", operandA, expectedOperand(srcA));
        checkOperand("operandB", operandB, expectedOperand(srcB));
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic driveStimulus(input int issueRate, input int resultRate,
                                 input logic narrowDest);
        robPkg::robTag_t         pending [$];
        logic [`ROB_ENTRIES-1:0] used;
        robPkg::robTag_t         freeTag;
        int                      pick;
        issue.valid   = (robQueue.size() < `ROB_ENTRIES) && (takeBits(4) < issueRate);
        issue.destReg = narrowDest ? robPkg::regAddr_t'(takeBits(2))
                                   : robPkg::regAddr_t'(takeBits(4));
        issue.hasDest = (takeBits(2) != 0);
        srcA = robPkg::regAddr_t'(takeBits(4));
        srcB = robPkg::regAddr_t'(takeBits(4));
        for (int i = 0; i < robQueue.size(); i++) begin
            if (!robQueue[i].done) begin
                pending.push_back(robQueue[i].tag);
            end
        end
        used = '0;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            cdb[p] = '0;
            if (takeBits(4) < resultRate) begin
                if (pending.size() > 0 && takeBits(4) != 0) begin
                    pick         = int'(takeBits(3)) % pending.size();   // out of order
                    cdb[p].valid = 1'b1;
                    cdb[p].tag   = pending[pick];
                    cdb[p].value = takeBits(32);
                    if (p == 0) begin
                        cdb[p].redirect = (takeBits(5) == 0);   // mispredicted branch
                    end
                    pending.delete(pick);
                end
                else begin
                    freeTag = robPkg::robTag_t'(takeBits(3));
                    if (findEntry(freeTag) < 0 && !used[freeTag]) begin
                        cdb[p].valid = 1'b1;
                        cdb[p].tag   = freeTag;
                        cdb[p].value = takeBits(32);
                    end
                end
                if (cdb[p].valid) begin
                    used[cdb[p].tag] = 1'b1;
                end
            end
        end
    endtask

    task automatic runCycle(input int issueRate, input int resultRate, input logic narrowDest);
        @(posedge CLK);
        #1;
        driveStimulus(issueRate, resultRate, narrowDest);
        #2;
        checkOutputs();
        applyEdge();
    endtask

    // idle buffer, so every operand comes straight from the register file
    task automatic sweepRegisters();
        for (int k = 0; k < `REG_COUNT / 2; k++) begin
            @(posedge CLK);
            #1;
            issue = '0;
            cdb   = '0;
            srcA  = robPkg::regAddr_t'(2 * k);
            srcB  = robPkg::regAddr_t'(2 * k + 1);
            #2;
            assert (operandA.ready && operandB.ready)
            else begin
                $display("register %0d or %0d still waits on a producer after the drain",
                         srcA, srcB);
                abortRun();
            end
            checkOutputs();
            applyEdge();
        end
    endtask

    task automatic reportCoverage(output logic ok);
        ok = 1'b1;
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (portDone[p] == 0) begin
                $display("result port %0d never completed an entry", p);
                ok = 1'b0;
            end
        end
        if (fullCycles == 0) begin
            $display("the reorder buffer never filled up");
            ok = 1'b0;
        end
        if (redirectCommits == 0) begin
            $display("no mispredicted branch was ever retired");
            ok = 1'b0;
        end
        if (regWrites == 0) begin
            $display("no instruction ever wrote the register file");
            ok = 1'b0;
        end
    endtask

    initial begin
        CLK             = 1'b0;
        Reset           = 1'b1;
        issue           = '0;
        cdb             = '0;
        srcA            = '0;
        srcB            = '0;
        lfsr            = SEED;
        tailTag         = '0;
        fullCycles      = 0;
        redirectCommits = 0;
        regWrites       = 0;
        for (int r = 0; r < `REG_COUNT; r++) begin
            modelRegs[r] = '0;
            producer[r]  = '0;
        end
        for (int p = 0; p < `CDB_PORTS; p++) begin
            portDone[p] = 0;
        end

        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        checkOutputs();   // reset state
        Reset = 1'b0;

        for (int c = 0; c < RUN_CYCLES; c++) begin
            case ((c / PHASE_CYCLES) % 4)
                0:       runCycle(14, 1, 1'b0);   // issue bursts fill the buffer
                1:       runCycle(0, 12, 1'b0);   // drain
                2:       runCycle(8, 6, 1'b1);    // few registers, many overlaps
                default: runCycle(8, 6, 1'b0);
            endcase
        end

        while (robQueue.size() > 0) begin
            runCycle(0, 12, 1'b0);
        end
        sweepRegisters();

        reportCoverage(coverageOk);
        if (coverageOk) begin
            $display("ALL TESTS PASSED");
            $finish;
        end
        else begin
            abortRun();
        end
    end

endmodule

`default_nettype wire

// ==== source/robTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module robTop (
    input  logic                CLK,
    input  logic                Reset,
    input  robPkg::issueReq_t   issue,
    input  robPkg::cdbBus_t     cdb,
    input  robPkg::regAddr_t    srcA,
    input  robPkg::regAddr_t    srcB,
    output logic                full,
    output robPkg::robTag_t     issueTag,
    output robPkg::commitInfo_t commit,
    output robPkg::operand_t    operandA,
    output robPkg::operand_t    operandB
);

    logic                allocate;
    logic                flush;
    logic                headDone;
    robPkg::robTag_t     headTag;
    robPkg::commitInfo_t headEntry;
    robPkg::regStatus_t  statusA;
    robPkg::regStatus_t  statusB;
    robPkg::dataWord_t   regValueA;
    robPkg::dataWord_t   regValueB;
    robPkg::operand_t    fwdA;
    robPkg::operand_t    fwdB;

    // ------------------------------------------------------------------------
    // reorder buffer
    // ------------------------------------------------------------------------
    robControl control (
        .CLK       (CLK),
        .Reset     (Reset),
        .issue     (issue),
        .headDone  (headDone),
        .headEntry (headEntry),
        .allocate  (allocate),
        .allocTag  (issueTag),    // tail tag is the issue tag
        .headTag   (headTag),
        .flush     (flush),
        .full      (full),
        .commit    (commit)
    );

    robEntryTable entries (
        .CLK        (CLK),
        .Reset      (Reset),
        .allocate   (allocate),
        .allocTag   (issueTag),
        .issue      (issue),
        .flush      (flush),
        .commitFree (commit.valid),
        .headTag    (headTag),
        .cdb        (cdb),
        .headDone   (headDone),
        .headEntry  (headEntry),
        .fwdTagA    (statusA.tag),
        .fwdTagB    (statusB.tag),
        .fwdA       (fwdA),
        .fwdB       (fwdB)
    );

    // ------------------------------------------------------------------------
    // operand side
    // ------------------------------------------------------------------------
    registerStatus status (
        .CLK      (CLK),
        .Reset    (Reset),
        .allocate (allocate),
        .allocTag (issueTag),
        .issue    (issue),
        .commit   (commit),
        .headTag  (headTag),
        .flush    (flush),
        .queryA   (srcA),
        .queryB   (srcB),
        .statusA  (statusA),
        .statusB  (statusB)
    );

    operandRead operands (
        .statusA   (statusA),
        .statusB   (statusB),
        .regValueA (regValueA),
        .regValueB (regValueB),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .operandA  (operandA),
        .operandB  (operandB)
    );

    archRegFile regFile (
        .CLK    (CLK),
        .Reset  (Reset),
        .commit (commit),
        .readA  (srcA),
        .readB  (srcB),
        .dataA  (regValueA),
        .dataB  (regValueB)
    );

endmodule

`default_nettype wire

// ==== source/archRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module archRegFile (
    input  logic                CLK,
    input  logic                Reset,
    input  robPkg::commitInfo_t commit,
    input  robPkg::regAddr_t    readA,
    input  robPkg::regAddr_t    readB,
    output robPkg::dataWord_t   dataA,
    output robPkg::dataWord_t   dataB
);

    robPkg::dataWord_t regs [`REG_COUNT];

    // committed state only
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                regs[r] <= '0;
            end
        end
        else if (commit.valid && commit.writeReg) begin
            regs[commit.destReg] <= commit.value;
        end
    end

    assign dataA = regs[readA];
    assign dataB = regs[readB];

endmodule

`default_nettype wire

// ==== source/operandRead.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandRead (
    input  robPkg::regStatus_t statusA,
    input  robPkg::regStatus_t statusB,
    input  robPkg::dataWord_t  regValueA,
    input  robPkg::dataWord_t  regValueB,
    input  robPkg::operand_t   fwdA,
    input  robPkg::operand_t   fwdB,
    output robPkg::operand_t   operandA,
    output robPkg::operand_t   operandB
);

    // value from regfile, value from finished producer, or tag to wait on
    function automatic robPkg::operand_t resolve(
        input robPkg::regStatus_t status,
        input robPkg::dataWord_t  regValue,
        input robPkg::operand_t   fwd
    );
        robPkg::operand_t res;
        res = '0;
        if (!status.busy) begin
            res.ready = 1'b1;
            res.value = regValue;
        end
        else if (fwd.ready) begin
            res.ready = 1'b1;
            res.value = fwd.value;
            res.tag   = status.tag;
        end
        else begin
            res.tag = status.tag;   // still executing
        end
        return res;
    endfunction

    assign operandA = resolve(statusA, regValueA, fwdA);
    assign operandB = resolve(statusB, regValueB, fwdB);

endmodule

`default_nettype wire

// ==== source/registerStatus.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module registerStatus (
    input  logic                CLK,
    input  logic                Reset,
    input  logic                allocate,
    input  robPkg::robTag_t     allocTag,
    input  robPkg::issueReq_t   issue,
    input  robPkg::commitInfo_t commit,
    input  robPkg::robTag_t     headTag,
    input  logic                flush,
    input  robPkg::regAddr_t    queryA,
    input  robPkg::regAddr_t    queryB,
    output robPkg::regStatus_t  statusA,
    output robPkg::regStatus_t  statusB
);

    // youngest in-flight producer per register
    robPkg::regStatus_t statusTable [`REG_COUNT];

    logic headOwnsDest;

    assign headOwnsDest = statusTable[commit.destReg].busy
                       && (statusTable[commit.destReg].tag == headTag);

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                statusTable[r] <= '0;
            end
        end
        else if (flush) begin
            for (int r = 0; r < `REG_COUNT; r++) begin
                statusTable[r] <= '0;
            end
        end
        else begin
            // only release if no younger producer took over
            if (commit.valid && commit.writeReg && headOwnsDest) begin
                statusTable[commit.destReg].busy <= 1'b0;
            end
            // later assignment wins over the release above
            if (allocate && issue.hasDest) begin
                statusTable[issue.destReg] <= '{busy: 1'b1, tag: allocTag};
            end
        end
    end

    assign statusA = statusTable[queryA];
    assign statusB = statusTable[queryB];

endmodule

`default_nettype wire

// ==== source/robEntryTable.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module robEntryTable (
    input  logic                CLK,
    input  logic                Reset,
    input  logic                allocate,
    input  robPkg::robTag_t     allocTag,
    input  robPkg::issueReq_t   issue,
    input  logic                flush,
    input  logic                commitFree,
    input  robPkg::robTag_t     headTag,
    input  robPkg::cdbBus_t     cdb,
    output logic                headDone,
    output robPkg::commitInfo_t headEntry,
    input  robPkg::robTag_t     fwdTagA,
    input  robPkg::robTag_t     fwdTagB,
    output robPkg::operand_t    fwdA,
    output robPkg::operand_t    fwdB
);

    logic [`ROB_ENTRIES-1:0] busy;
    logic [`ROB_ENTRIES-1:0] done;   // result has arrived

    // payload is only meaningful while busy
    robPkg::regAddr_t        destQ [`ROB_ENTRIES];
    robPkg::dataWord_t       valueQ [`ROB_ENTRIES];
    logic [`ROB_ENTRIES-1:0] hasDestQ;
    logic [`ROB_ENTRIES-1:0] redirectQ;

    logic dupTag;

    // ------------------------------------------------------------------------
    // entry state
    // ------------------------------------------------------------------------
    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            busy <= '0;
            done <= '0;
        end
        else if (flush) begin
            busy <= '0;
            done <= '0;
        end
        else begin
            if (commitFree) begin
                busy[headTag] <= 1'b0;
            end
            if (allocate) begin
                busy[allocTag] <= 1'b1;
                done[allocTag] <= 1'b0;
            end
            for (int p = 0; p < `CDB_PORTS; p++) begin
                if (cdb[p].valid && busy[cdb[p].tag]) begin
                    done[cdb[p].tag] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (allocate) begin
            destQ[allocTag]    <= issue.destReg;
            hasDestQ[allocTag] <= issue.hasDest;
        end
        for (int p = 0; p < `CDB_PORTS; p++) begin
            if (cdb[p].valid && busy[cdb[p].tag]) begin
                valueQ[cdb[p].tag]    <= cdb[p].value;
                redirectQ[cdb[p].tag] <= (p == 0) && cdb[p].redirect;  // integer port only
            end
        end
    end

    // ------------------------------------------------------------------------
    // read ports
    // ------------------------------------------------------------------------
    assign headDone = busy[headTag] && done[headTag];

    always_comb begin
        headEntry          = '0;
        headEntry.destReg  = destQ[headTag];
        headEntry.value    = valueQ[headTag];
        headEntry.writeReg = hasDestQ[headTag];
        headEntry.redirect = redirectQ[headTag];
    end

    assign fwdA = '{ready: busy[fwdTagA] && done[fwdTagA],
                    value: valueQ[fwdTagA],
                    tag:   fwdTagA};
    assign fwdB = '{ready: busy[fwdTagB] && done[fwdTagB],
                    value: valueQ[fwdTagB],
                    tag:   fwdTagB};

    // two units finishing the same instruction
    always_comb begin
        dupTag = 1'b0;
        for (int i = 0; i < `CDB_PORTS; i++) begin
            for (int j = i + 1; j < `CDB_PORTS; j++) begin
                if (cdb[i].valid && cdb[j].valid && (cdb[i].tag == cdb[j].tag)) begin
                    dupTag = 1'b1;
                end
            end
        end
    end

    dupBroadcast: assert property (@(posedge CLK) disable iff (Reset) !dupTag)
        else $error("two result ports carry the same tag");

endmodule

`default_nettype wire

// ==== source/robControl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rob_defs.svh"

module robControl (
    input  logic                CLK,
    input  logic                Reset,
    input  robPkg::issueReq_t   issue,
    input  logic                headDone,
    input  robPkg::commitInfo_t headEntry,
    output logic                allocate,
    output robPkg::robTag_t     allocTag,
    output robPkg::robTag_t     headTag,
    output logic                flush,
    output logic                full,
    output robPkg::commitInfo_t commit
);

    robPkg::robPtr_t head;
    robPkg::robPtr_t tail;
    robPkg::robPtr_t headNext;
    logic            empty;

    assign headTag  = head[`ROB_TAG_W-1:0];
    assign allocTag = tail[`ROB_TAG_W-1:0];
    assign headNext = head + robPkg::robPtr_t'(1);

    // same index, opposite wrap bit
    assign full  = (head == {~tail[`ROB_PTR_W-1], tail[`ROB_TAG_W-1:0]});
    assign empty = (head == tail);

    // ------------------------------------------------------------------------
    // commit decision
    // ------------------------------------------------------------------------
    always_comb begin
        commit = '0;
        if (headDone && !empty) begin
            commit.valid    = 1'b1;
            commit.destReg  = headEntry.destReg;
            commit.value    = headEntry.value;
            commit.redirect = headEntry.redirect;
            commit.writeReg = headEntry.writeReg && !headEntry.redirect; // no write on mispredict
        end
    end

    assign flush    = commit.valid && commit.redirect;
    assign allocate = issue.valid && !full && !flush;   // issue dropped on flush

    always_ff @(posedge CLK or posedge Reset) begin
        if (Reset) begin
            head <= '0;
            tail <= '0;
        end
        else begin
            if (commit.valid) begin
                head <= headNext;
            end
            if (flush) begin
                tail <= headNext;   // everything younger is gone
            end
            else if (allocate) begin
                tail <= tail + robPkg::robPtr_t'(1);
            end
        end
    end

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    issueWhileFull: assert property (@(posedge CLK) disable iff (Reset)
        !(issue.valid && full))
        else $error("issue while reorder buffer full");

    // entry table must never present a done head when nothing is in flight
    doneWhileEmpty: assert property (@(posedge CLK) disable iff (Reset)
        empty |-> !headDone)
        else $error("head entry done while buffer empty");

endmodule

`default_nettype wire

// ==== source/robPkg.sv ====
`default_nettype none

`include "rob_defs.svh"

package robPkg;

    typedef logic [`ROB_TAG_W-1:0]  robTag_t;
    typedef logic [`ROB_PTR_W-1:0]  robPtr_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;
    typedef logic [`DATA_W-1:0]     dataWord_t;

    typedef struct packed {
        logic     valid;
        regAddr_t destReg;
        logic     hasDest;
    } issueReq_t;

    // one result bus; redirect only meaningful on the integer port
    typedef struct packed {
        logic      valid;
        robTag_t   tag;
        dataWord_t value;
        logic      redirect;
    } cdbPort_t;

    // [0] integer, [1] memory, [2] multiply, [3] float
    typedef cdbPort_t [`CDB_PORTS-1:0] cdbBus_t;

    typedef struct packed {
        logic      valid;
        regAddr_t  destReg;
        dataWord_t value;
        logic      writeReg;
        logic      redirect;
    } commitInfo_t;

    typedef struct packed {
        logic      ready;
        dataWord_t value;
        robTag_t   tag;   // producer to wait on when not ready
    } operand_t;

    typedef struct packed {
        logic    busy;
        robTag_t tag;
    } regStatus_t;

endpackage

`default_nettype wire

// ==== source/rob_defs.svh ====
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// ---------------------------------------------------------------------------
// reorder buffer geometry
// ---------------------------------------------------------------------------
`define ROB_ENTRIES 8
`define ROB_PTR_W   4   // index plus wrap bit
`define ROB_TAG_W   3

// ---------------------------------------------------------------------------
// architectural state
// ---------------------------------------------------------------------------
`define REG_COUNT   16
`define REG_ADDR_W  4
`define DATA_W      32

`define CDB_PORTS   4   // integer, memory, multiply, float

`endif
